// ==== design/scope_pkg.sv ====
// Shared constants and the generator state type for the oscilloscope capture path

`default_nettype none

package scope_pkg;

    // Stream word layout
    localparam int data_width = 32;
    localparam int channel_width = 8;

    // Channel numbering and the data pattern of the sample generator
    localparam int first_channel = 1;
    localparam int n_channels = 6;
    localparam int channel_step = 2000;
    localparam int output_bias = 0;

    // Packet length input and memory address widths
    localparam int length_width = 16;
    localparam int address_width = 16;

    // Quiet time after each completed packet, in clock cycles
    localparam int backoff_cycles = 16;
    localparam int backoff_width = $clog2(backoff_cycles + 1);

    // Stream buffer sizing
    localparam int fifo_depth = 8;
    localparam int fifo_pointer_width = $clog2(fifo_depth);
    localparam int fifo_count_width = $clog2(fifo_depth + 1);

    // Capture sequencer states
    typedef enum logic [2:0] {
        idle,
        wait_tick,
        emit,
        wait_done,
        backoff
    } gen_state_t;

endpackage

`default_nettype wire

// ==== design/scope_sample_gen.sv ====
// Sample generator that sequences captures and emits channel-tagged words

`timescale 1ns/1ps
`default_nettype none

module scope_sample_gen
    import scope_pkg::*;
(
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      enable,
    input  wire                      trigger,
    input  wire                      timebase,
    input  wire [length_width-1:0]   packet_length,
    input  wire                      gen_ready,
    input  wire                      capture_done,
    output logic                     gen_valid,
    output logic [data_width-1:0]    gen_data,
    output logic [channel_width-1:0] gen_channel,
    output logic                     gen_last,
    output logic                     busy
);

    localparam logic [channel_width-1:0] channel_low = channel_width'(first_channel);
    localparam logic [channel_width-1:0] channel_high =
        channel_width'(first_channel + n_channels - 1);

    gen_state_t state;

    logic                     trigger_q;
    logic [length_width-1:0]  sample_index;
    logic [channel_width-1:0] channel;
    logic [backoff_width-1:0] backoff_count;

    logic                     start;
    logic                     accepted;
    logic                     last_channel;
    logic                     last_sample;
    logic [channel_width-1:0] channel_index;

    // Either the enable level or a fresh rising edge on trigger arms a capture
    assign start = enable || (trigger && !trigger_q);

    assign accepted = gen_valid && gen_ready;
    assign last_channel = (channel == channel_high);
    assign last_sample = (sample_index == packet_length - 1'b1);

    // Word value follows the sample index plus a fixed offset per channel
    assign channel_index = channel - channel_low;
    assign gen_data = data_width'(output_bias) + data_width'(sample_index)
                    + data_width'(channel_step) * data_width'(channel_index);

    // The payload comes straight from the counters, so it holds while a word waits
    assign gen_valid = (state == emit);
    assign gen_channel = channel;
    assign gen_last = last_channel && last_sample;
    assign busy = (state != idle);

    always_ff @(posedge clock) begin
        if (!reset) begin
            trigger_q <= 1'b0;
        end else begin
            trigger_q <= trigger;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            sample_index <= '0;
            channel <= channel_low;
            backoff_count <= '0;
        end else begin
            case (state)
                idle: begin
                    sample_index <= '0;
                    channel <= channel_low;
                    if (start) begin
                        state <= wait_tick;
                    end
                end

                wait_tick: begin
                    if (timebase) begin
                        state <= emit;
                    end
                end

                emit: begin
                    // Ticks seen here are dropped, the sample set is finished first
                    if (accepted) begin
                        if (last_channel) begin
                            channel <= channel_low;
                            if (last_sample) begin
                                sample_index <= '0;
                                state <= wait_done;
                            end else begin
                                sample_index <= sample_index + 1'b1;
                                state <= wait_tick;
                            end
                        end else begin
                            channel <= channel + 1'b1;
                        end
                    end
                end

                wait_done: begin
                    backoff_count <= '0;
                    if (capture_done) begin
                        state <= backoff;
                    end
                end

                backoff: begin
                    if (backoff_count == backoff_width'(backoff_cycles - 1)) begin
                        state <= idle;
                    end else begin
                        backoff_count <= backoff_count + 1'b1;
                    end
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/scope_stream_fifo.sv ====
// Valid/ready stream FIFO carrying sample data, channel tag and last flag

`timescale 1ns/1ps
`default_nettype none

module scope_stream_fifo
    import scope_pkg::*;
(
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      gen_valid,
    input  wire [data_width-1:0]     gen_data,
    input  wire [channel_width-1:0]  gen_channel,
    input  wire                      gen_last,
    output logic                     gen_ready,
    output logic                     buf_valid,
    output logic [data_width-1:0]    buf_data,
    output logic [channel_width-1:0] buf_channel,
    output logic                     buf_last,
    input  wire                      buf_ready
);

    // Entry storage, one array per field
    logic [data_width-1:0]    data_mem    [fifo_depth];
    logic [channel_width-1:0] channel_mem [fifo_depth];
    logic                     last_mem    [fifo_depth];

    logic [fifo_pointer_width-1:0] write_pointer;
    logic [fifo_pointer_width-1:0] read_pointer;
    logic [fifo_count_width-1:0]   count;

    logic push;
    logic pop;

    assign gen_ready = (count != fifo_count_width'(fifo_depth));
    assign buf_valid = (count != '0);

    assign push = gen_valid && gen_ready;
    assign pop = buf_valid && buf_ready;

    // Head entry is read without a register stage
    assign buf_data = data_mem[read_pointer];
    assign buf_channel = channel_mem[read_pointer];
    assign buf_last = last_mem[read_pointer];

    always_ff @(posedge clock) begin
        if (push) begin
            data_mem[write_pointer] <= gen_data;
            channel_mem[write_pointer] <= gen_channel;
            last_mem[write_pointer] <= gen_last;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_pointer <= '0;
            read_pointer <= '0;
            count <= '0;
        end else begin
            if (push) begin
                if (write_pointer == fifo_pointer_width'(fifo_depth - 1)) begin
                    write_pointer <= '0;
                end else begin
                    write_pointer <= write_pointer + 1'b1;
                end
            end

            if (pop) begin
                if (read_pointer == fifo_pointer_width'(fifo_depth - 1)) begin
                    read_pointer <= '0;
                end else begin
                    read_pointer <= read_pointer + 1'b1;
                end
            end

            // A push and a pop in the same cycle leave the occupancy unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/scope_capture_writer.sv ====
// Capture writer that turns stream words into addressed memory writes
// and reports each completed packet

`timescale 1ns/1ps
`default_nettype none

module scope_capture_writer
    import scope_pkg::*;
(
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      buf_valid,
    input  wire [data_width-1:0]     buf_data,
    input  wire [channel_width-1:0]  buf_channel,
    input  wire                      buf_last,
    output logic                     buf_ready,
    output logic                     mem_valid,
    output logic [address_width-1:0] mem_address,
    output logic [data_width-1:0]    mem_data,
    output logic [channel_width-1:0] mem_channel,
    output logic                     mem_last,
    input  wire                      mem_ready,
    output logic                     capture_done,
    output logic [15:0]              capture_count
);

    logic [address_width-1:0] write_address;
    logic [address_width-1:0] address_next;

    logic take;
    logic written;

    // The output register takes a word when empty or while its word leaves
    assign buf_ready = !mem_valid || mem_ready;

    assign take = buf_valid && buf_ready;
    assign written = mem_valid && mem_ready;

    // Address for the next registered word
    // A completed write advances it, and a completed last write restarts the packet at 0
    always_comb begin
        if (written) begin
            if (mem_last) begin
                address_next = '0;
            end else begin
                address_next = mem_address + 1'b1;
            end
        end else begin
            address_next = write_address;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            mem_valid <= 1'b0;
            write_address <= '0;
        end else begin
            write_address <= address_next;
            if (take) begin
                mem_valid <= 1'b1;
            end else if (written) begin
                mem_valid <= 1'b0;
            end
        end
    end

    // Payload of the memory port, loaded only when a word is taken
    always_ff @(posedge clock) begin
        if (take) begin
            mem_address <= address_next;
            mem_data <= buf_data;
            mem_channel <= buf_channel;
            mem_last <= buf_last;
        end
    end

    // Packet completion goes back to the generator one cycle after the last write
    always_ff @(posedge clock) begin
        if (!reset) begin
            capture_done <= 1'b0;
            capture_count <= '0;
        end else begin
            capture_done <= written && mem_last;
            if (written && mem_last) begin
                capture_count <= capture_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/scope_capture_top.sv ====
// Top level of the capture path joining sample generator, stream FIFO and writer

`timescale 1ns/1ps
`default_nettype none

module scope_capture_top
    import scope_pkg::*;
(
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      enable,
    input  wire                      trigger,
    input  wire                      timebase,
    input  wire [length_width-1:0]   packet_length,
    output logic                     mem_valid,
    output logic [address_width-1:0] mem_address,
    output logic [data_width-1:0]    mem_data,
    output logic [channel_width-1:0] mem_channel,
    output logic                     mem_last,
    input  wire                      mem_ready,
    output logic [15:0]              capture_count,
    output logic                     busy
);

    // Generator to FIFO stream
    logic                     gen_valid;
    logic                     gen_ready;
    logic [data_width-1:0]    gen_data;
    logic [channel_width-1:0] gen_channel;
    logic                     gen_last;

    // FIFO to writer stream
    logic                     buf_valid;
    logic                     buf_ready;
    logic [data_width-1:0]    buf_data;
    logic [channel_width-1:0] buf_channel;
    logic                     buf_last;

    logic capture_done;

    scope_sample_gen scope_sample_gen_i (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .trigger       (trigger),
        .timebase      (timebase),
        .packet_length (packet_length),
        .gen_ready     (gen_ready),
        .capture_done  (capture_done),
        .gen_valid     (gen_valid),
        .gen_data      (gen_data),
        .gen_channel   (gen_channel),
        .gen_last      (gen_last),
        .busy          (busy)
    );

    scope_stream_fifo scope_stream_fifo_i (
        .clock       (clock),
        .reset       (reset),
        .gen_valid   (gen_valid),
        .gen_data    (gen_data),
        .gen_channel (gen_channel),
        .gen_last    (gen_last),
        .gen_ready   (gen_ready),
        .buf_valid   (buf_valid),
        .buf_data    (buf_data),
        .buf_channel (buf_channel),
        .buf_last    (buf_last),
        .buf_ready   (buf_ready)
    );

    scope_capture_writer scope_capture_writer_i (
        .clock         (clock),
        .reset         (reset),
        .buf_valid     (buf_valid),
        .buf_data      (buf_data),
        .buf_channel   (buf_channel),
        .buf_last      (buf_last),
        .buf_ready     (buf_ready),
        .mem_valid     (mem_valid),
        .mem_address   (mem_address),
        .mem_data      (mem_data),
        .mem_channel   (mem_channel),
        .mem_last      (mem_last),
        .mem_ready     (mem_ready),
        .capture_done  (capture_done),
        .capture_count (capture_count)
    );

endmodule

`default_nettype wire

// ==== verif/scope_clock_gen.sv ====
// Testbench clock with a 10 ns period and an active low reset held for 8 cycles

`timescale 1ns/1ps
`default_nettype none

module scope_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Reset is released on a falling edge, away from the DUT's sampling edge
    initial begin
        reset = 1'b0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/scope_capture_tb.sv ====
// Testbench for the capture path with a reference model of the memory writes
// and random back-pressure on the memory port

`timescale 1ns/1ps
`default_nettype none

module scope_capture_tb
    import scope_pkg::*;
();

    localparam int wait_limit = 20000;
    localparam int max_words = 64;

    wire clock;
    wire reset;

    logic                     enable;
    logic                     trigger;
    logic                     timebase = 1'b0;
    logic [length_width-1:0]  packet_length;
    logic                     mem_ready = 1'b0;

    wire                      mem_valid;
    wire [address_width-1:0]  mem_address;
    wire [data_width-1:0]     mem_data;
    wire [channel_width-1:0]  mem_channel;
    wire                      mem_last;
    wire [15:0]               capture_count;
    wire                      busy;

    logic [31:0] test_words [max_words];

    // Stimulus settings of the running case
    int          tick_period = 1;
    int          tick_counter = 0;
    logic [31:0] stall_mask = '0;
    logic [31:0] rng_state = 32'h20f36626;

    // Reference model and monitor state
    int                       write_index = 0;
    int                       packets_written = 0;
    int                       busy_run = 0;
    logic                     busy_tracking = 1'b0;
    logic                     done_pending = 1'b0;
    logic [15:0]              last_count = '0;
    logic                     hold_pending = 1'b0;
    logic [address_width-1:0] held_address;
    logic [data_width-1:0]    held_data;
    logic [channel_width-1:0] held_channel;
    logic                     held_last;

    gen_state_t gen_state;
    assign gen_state = scope_capture_top_i.scope_sample_gen_i.state;

    scope_clock_gen scope_clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    scope_capture_top scope_capture_top_i (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .trigger       (trigger),
        .timebase      (timebase),
        .packet_length (packet_length),
        .mem_valid     (mem_valid),
        .mem_address   (mem_address),
        .mem_data      (mem_data),
        .mem_channel   (mem_channel),
        .mem_last      (mem_last),
        .mem_ready     (mem_ready),
        .capture_count (capture_count),
        .busy          (busy)
    );

    function automatic logic [31:0] next_random(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string message);
        $display("** Error at %0t: %s", $time, message);
        $display("Checks failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_problem(input string message);
        $display("Failure at %0t: %s, generator in state %s", $time, message, gen_state.name());
        $display("Checks failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic wait_busy(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (busy !== level && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        assert (busy === level)
        else report_problem($sformatf("timed out after %0d cycles waiting for %s",
                                      wait_limit, what));
    endtask

    task automatic wait_capture_count(input int expected);
        int cycles;
        cycles = 0;
        while (capture_count !== 16'(expected) && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        assert (capture_count === 16'(expected))
        else report_problem($sformatf("packet %0d was not completed within %0d cycles",
                                      expected, wait_limit));
    endtask

    // Drives timebase and mem_ready for the coming rising edge and checks the memory port
    always @(negedge clock) begin
        logic [31:0]           drawn;
        int                    packet_words;
        int                    expected_sample;
        int                    expected_channel;
        logic [data_width-1:0] expected_data;
        logic                  expected_last;

        if (tick_counter + 1 >= tick_period) begin
            timebase = 1'b1;
            tick_counter = 0;
        end else begin
            timebase = 1'b0;
            tick_counter++;
        end

        drawn = next_random(rng_state);
        rng_state = drawn;
        mem_ready = ((drawn & stall_mask) == '0);

        if (reset) begin
            // A stalled write must keep its payload
            if (hold_pending) begin
                assert (mem_valid && mem_address == held_address && mem_data == held_data
                        && mem_channel == held_channel && mem_last == held_last)
                else report_mismatch($sformatf("stalled write at address %0d changed",
                                               held_address));
            end
            hold_pending = mem_valid && !mem_ready;
            held_address = mem_address;
            held_data = mem_data;
            held_channel = mem_channel;
            held_last = mem_last;

            if (busy_tracking) begin
                if (busy) begin
                    busy_run++;
                end else begin
                    assert (busy_run >= backoff_cycles)
                    else report_mismatch($sformatf("busy fell %0d cycles after the last write",
                                                   busy_run));
                    busy_tracking = 1'b0;
                end
            end

            if (capture_count != last_count) begin
                assert (done_pending && capture_count == last_count + 16'd1)
                else report_mismatch($sformatf("capture_count went from %0d to %0d",
                                               last_count, capture_count));
                done_pending = 1'b0;
                last_count = capture_count;
            end

            // The write is accepted on the next rising edge
            if (mem_valid && mem_ready) begin
                packet_words = int'(packet_length) * n_channels;
                expected_sample = write_index / n_channels;
                expected_channel = first_channel + write_index % n_channels;
                expected_data = data_width'(output_bias + expected_sample
                                + channel_step * (expected_channel - first_channel));
                expected_last = (write_index == packet_words - 1);

                assert (write_index < packet_words)
                else report_mismatch($sformatf("write %0d beyond packet of %0d words",
                                               write_index, packet_words));
                assert (mem_address == address_width'(write_index))
                else report_mismatch($sformatf("address %0d, expected %0d",
                                               mem_address, write_index));
                assert (mem_data == expected_data)
                else report_mismatch($sformatf("data %0d at address %0d, expected %0d",
                                               mem_data, write_index, expected_data));
                assert (mem_channel == channel_width'(expected_channel))
                else report_mismatch($sformatf("channel %0d at address %0d, expected %0d",
                                               mem_channel, write_index, expected_channel));
                assert (mem_last == expected_last)
                else report_mismatch($sformatf("last flag %0d at address %0d, expected %0d",
                                               mem_last, write_index, expected_last));

                if (expected_last) begin
                    write_index = 0;
                    packets_written++;
                    done_pending = 1'b1;
                    busy_tracking = 1'b1;
                    busy_run = 0;
                end else begin
                    write_index++;
                end
            end
        end
    end

    initial begin
        int case_count;
        int base;
        int mode;
        int cycles;

        enable = 1'b0;
        trigger = 1'b0;
        packet_length = length_width'(1);

        $readmemh("verif/scope_capture_testdata.txt", test_words);
        case_count = test_words[0];
        assert (!$isunknown(test_words[0]) && case_count > 0
                && 4 * case_count + 1 <= max_words)
        else report_problem("the test data file is missing or holds a bad case count");

        cycles = 0;
        while (reset !== 1'b1 && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        assert (reset === 1'b1) else report_problem("reset was never released");

        @(negedge clock);
        assert (!mem_valid && !busy && capture_count == '0)
        else report_mismatch("outputs not idle after reset");

        for (int case_index = 0; case_index < case_count; case_index++) begin
            base = 1 + 4 * case_index;
            mode = test_words[base];
            assert (mode == 0 || mode == 1)
            else report_problem($sformatf("unknown start mode in test case %0d", case_index));
            packet_length = length_width'(test_words[base + 1]);
            tick_period = test_words[base + 2];
            stall_mask = test_words[base + 3];
            $display("Case %0d: %s start, %0d sample sets, tick every %0d, generator %s",
                     case_index, (mode == 0) ? "enable" : "trigger", packet_length,
                     tick_period, gen_state.name());

            @(negedge clock);
            assert (!busy) else report_mismatch("busy high before the capture starts");

            if (mode == 0) begin
                enable = 1'b1;
                wait_busy(1'b1, "the enable start");
                enable = 1'b0;
            end else begin
                trigger = 1'b1;
                wait_busy(1'b1, "the trigger start");
            end

            wait_capture_count(case_index + 1);
            assert (packets_written == case_index + 1)
            else report_mismatch($sformatf("%0d packets written, expected %0d",
                                           packets_written, case_index + 1));

            wait_busy(1'b0, "the end of the back-off");

            // Trigger stays high, and without a new edge nothing may start
            if (mode == 1) begin
                repeat (2 * backoff_cycles) begin
                    @(negedge clock);
                    assert (!busy && !mem_valid)
                    else report_mismatch("a held trigger started another capture");
                end
                trigger = 1'b0;
                @(negedge clock);
            end
        end

        assert (capture_count == 16'(case_count))
        else report_mismatch($sformatf("capture_count %0d, expected %0d",
                                       capture_count, case_count));

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/scope_pkg.sv
design/scope_sample_gen.sv
design/scope_stream_fifo.sv
design/scope_capture_writer.sv
design/scope_capture_top.sv
verif/scope_clock_gen.sv
verif/scope_capture_tb.sv

// ==== verif/scope_capture_testdata.txt ====
// First word: number of test cases, then one case per line, all values in hex
// mode (0 enable, 1 trigger)  packet_length  timebase_period  mem_ready_stall_mask
a
0 0001 0001 00000000
1 0003 0004 00000000
0 0004 0002 00000001
1 0005 0008 00000003
0 0008 0001 00000007
1 0002 000c 00000001
0 000c 0003 00000000
1 0006 0001 0000000f
0 0010 0005 00000003
1 000a 0002 00000001
